/* list.f */
src/scene_pkg.sv
src/player_if.sv
src/terrain_region.sv
src/terrain_map.sv
src/player_sprite.sv
src/pixel_compositor.sv
src/scene_top.sv
tb/tb_clock.sv
tb/tb_scene.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_scene -f list.f -o tb_scene

out=$(./obj_dir/tb_scene)
echo "$out"
echo "$out" | grep -q "^TESTBENCH PASSED$"

/* src/pixel_compositor.sv */
`timescale 1ns/1ps

module pixel_compositor import scene_pkg::*; #(
    parameter logic [ADDR_W-1:0] BG_ADDR = 17'd12900
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              terrain_hit,
    input  logic              player_hit,
    input  logic [ADDR_W-1:0] terrain_addr,
    input  logic [ADDR_W-1:0] player_addr,
    output logic [ADDR_W-1:0] addr,
    output logic              sprite_on
);

    logic [ADDR_W-1:0] addr_next;

    // player over terrain over background.
    always_comb begin
        if (player_hit) begin
            addr_next = player_addr;
        end else if (terrain_hit) begin
            addr_next = terrain_addr;
        end else begin
            addr_next = BG_ADDR;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr      <= BG_ADDR;
            sprite_on <= 1'b0;
        end else begin
            addr      <= addr_next;
            sprite_on <= player_hit;  // marks a player pixel.
        end
    end

    a_addr_known : assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(addr));

endmodule

/* src/player_if.sv */
`timescale 1ns/1ps

interface player_if import scene_pkg::*; ();

    logic [COORD_W-1:0] px;     // box left edge.
    logic [COORD_W-1:0] py;     // box top edge.
    logic [3:0]         state;
    logic [1:0]         jump;

    modport sprite_view (
        input px,
        input py,
        input state,
        input jump
    );

    modport terrain_view (
        input px,
        input py
    );

endinterface

/* src/player_sprite.sv */
`timescale 1ns/1ps

module player_sprite import scene_pkg::*; #(
    parameter int SHEET_W = 320
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [COORD_W-1:0] vga_h,
    input  logic [COORD_W-1:0] vga_v,
    player_if.sprite_view      player,
    output logic               player_hit,
    output logic [ADDR_W-1:0]  player_addr
);

    localparam int EXT_W = COORD_W + 1;

    logic [1:0]        frame;
    logic [EXT_W-1:0]  box_r, box_b;
    logic              in_box;
    logic [ADDR_W-1:0] row, col;

    // jumping overrides the walk frames.
    always_comb begin
        if (player.jump != 2'd0) begin
            frame = 2'd3;
        end else begin
            case (player.state)
                ST_STATIC: frame = 2'd0;
                ST_RIGHT:  frame = 2'd1;
                ST_LEFT:   frame = 2'd2;
                ST_UP:     frame = 2'd3;
                default:   frame = 2'd0;
            endcase
        end
    end

    assign box_r = EXT_W'(player.px) + EXT_W'(PLAYER_W);
    assign box_b = EXT_W'(player.py) + EXT_W'(PLAYER_H);

    // clipped to the screen, the box may hang past the right edge.
    assign in_box = (vga_h >= player.px) && (EXT_W'(vga_h) < box_r) &&
                    (vga_v >= player.py) && (EXT_W'(vga_v) < box_b) &&
                    (vga_h < COORD_W'(SCREEN_W)) && (vga_v < COORD_W'(SCREEN_H));

    assign row = ADDR_W'(PLAYER_MEM_V) + ADDR_W'(vga_v) - ADDR_W'(player.py);
    assign col = ADDR_W'(PLAYER_MEM_H) + ADDR_W'(frame) * ADDR_W'(PLAYER_W) +
                 ADDR_W'(vga_h) - ADDR_W'(player.px);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            player_hit <= 1'b0;
        end else begin
            player_hit <= in_box;
        end
    end

    always_ff @(posedge clk) begin
        player_addr <= ADDR_W'(row * SHEET_W) + col;
    end

    a_hit_in_box : assert property (@(posedge clk) disable iff (!rst_n)
        player_hit |->
            (COORD_W'($past(vga_h) - $past(player.px)) < COORD_W'(PLAYER_W)) &&
            (COORD_W'($past(vga_v) - $past(player.py)) < COORD_W'(PLAYER_H)));

endmodule

/* src/scene_pkg.sv */
package scene_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int COORD_W = 10;  // screen and sheet coordinates.
    localparam int ADDR_W  = 17;  // sprite sheet address.

    // ----------------------------------------
    // screen and sprite geometry
    // ----------------------------------------
    localparam int SCREEN_W = 320;
    localparam int SCREEN_H = 240;

    localparam int PLAYER_W = 16;  // player box and frame pitch.
    localparam int PLAYER_H = 20;

    localparam int PLAYER_MEM_H = 0;    // first animation frame in the sheet.
    localparam int PLAYER_MEM_V = 100;

    // ----------------------------------------
    // region kinds and player states
    // ----------------------------------------
    localparam logic [1:0] KIND_SOLID = 2'd0;
    localparam logic [1:0] KIND_RED   = 2'd1;
    localparam logic [1:0] KIND_BLUE  = 2'd2;

    localparam logic [3:0] ST_STATIC = 4'd6;
    localparam logic [3:0] ST_RIGHT  = 4'd7;
    localparam logic [3:0] ST_LEFT   = 4'd8;
    localparam logic [3:0] ST_UP     = 4'd9;

    localparam int N_REGIONS = 7;  // regions per map.

endpackage

/* src/scene_top.sv */
`timescale 1ns/1ps

module scene_top import scene_pkg::*; #(
    parameter int                SHEET_W = 320,
    parameter logic [ADDR_W-1:0] BG_ADDR = 17'd12900
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               map_sel,
    input  logic [COORD_W-1:0] vga_h,
    input  logic [COORD_W-1:0] vga_v,
    input  logic [COORD_W-1:0] player_x,
    input  logic [COORD_W-1:0] player_y,
    input  logic [3:0]         player_state,
    input  logic [1:0]         player_jump,
    output logic [ADDR_W-1:0]  addr,
    output logic               sprite_on,
    output logic               touch_solid,
    output logic               touch_red,
    output logic               touch_blue
);

    logic              terrain_hit, player_hit;
    logic [ADDR_W-1:0] terrain_addr, player_addr;

    // ----------------------------------------
    // player bundle
    // ----------------------------------------
    player_if u_player ();

    assign u_player.px    = player_x;
    assign u_player.py    = player_y;
    assign u_player.state = player_state;
    assign u_player.jump  = player_jump;

    // ----------------------------------------
    // layers
    // ----------------------------------------
    terrain_map #(
        .SHEET_W (SHEET_W)
    ) u_terrain (
        .clk          (clk),
        .rst_n        (rst_n),
        .map_sel      (map_sel),
        .vga_h        (vga_h),
        .vga_v        (vga_v),
        .player       (u_player.terrain_view),
        .terrain_hit  (terrain_hit),
        .terrain_addr (terrain_addr),
        .touch_solid  (touch_solid),
        .touch_red    (touch_red),
        .touch_blue   (touch_blue)
    );

    player_sprite #(
        .SHEET_W (SHEET_W)
    ) u_sprite (
        .clk         (clk),
        .rst_n       (rst_n),
        .vga_h       (vga_h),
        .vga_v       (vga_v),
        .player      (u_player.sprite_view),
        .player_hit  (player_hit),
        .player_addr (player_addr)
    );

    pixel_compositor #(
        .BG_ADDR (BG_ADDR)
    ) u_compositor (
        .clk          (clk),
        .rst_n        (rst_n),
        .terrain_hit  (terrain_hit),
        .player_hit   (player_hit),
        .terrain_addr (terrain_addr),
        .player_addr  (player_addr),
        .addr         (addr),
        .sprite_on    (sprite_on)
    );

endmodule

/* src/terrain_map.sv */
`timescale 1ns/1ps

module terrain_map import scene_pkg::*; #(
    parameter int SHEET_W = 320
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               map_sel,
    input  logic [COORD_W-1:0] vga_h,
    input  logic [COORD_W-1:0] vga_v,
    player_if.terrain_view     player,
    output logic               terrain_hit,
    output logic [ADDR_W-1:0]  terrain_addr,
    output logic               touch_solid,
    output logic               touch_red,
    output logic               touch_blue
);

    // ----------------------------------------
    // layout tables, in priority order
    // ----------------------------------------
    // ceiling, red river, blue river, floor, left, right, wall.
    localparam logic [COORD_W-1:0] PH [2][N_REGIONS] = '{
        '{10'd0, 10'd150, 10'd210, 10'd0, 10'd0, 10'd310, 10'd10},
        '{10'd0, 10'd60,  10'd240, 10'd0, 10'd0, 10'd310, 10'd200}
    };
    localparam logic [COORD_W-1:0] PV [2][N_REGIONS] = '{
        '{10'd0, 10'd230, 10'd230, 10'd230, 10'd10, 10'd10, 10'd190},
        '{10'd0, 10'd230, 10'd230, 10'd230, 10'd10, 10'd10, 10'd150}
    };
    localparam logic [COORD_W-1:0] W [2][N_REGIONS] = '{
        '{10'd320, 10'd40, 10'd40, 10'd320, 10'd10, 10'd10, 10'd105},
        '{10'd320, 10'd40, 10'd40, 10'd320, 10'd10, 10'd10, 10'd110}
    };

    // same in both maps.
    localparam logic [COORD_W-1:0] H [N_REGIONS] =
        '{10'd10, 10'd6, 10'd6, 10'd10, 10'd220, 10'd220, 10'd8};
    localparam logic [COORD_W-1:0] MH [N_REGIONS] =
        '{10'd0, 10'd0, 10'd55, 10'd0, 10'd305, 10'd305, 10'd50};
    localparam logic [COORD_W-1:0] MV [N_REGIONS] =
        '{10'd220, 10'd65, 10'd70, 10'd220, 10'd10, 10'd10, 10'd215};
    localparam logic [1:0] KIND [N_REGIONS] = '{KIND_SOLID, KIND_RED, KIND_BLUE,
        KIND_SOLID, KIND_SOLID, KIND_SOLID, KIND_SOLID};

    logic [N_REGIONS-1:0] hit_v;
    logic [N_REGIONS-1:0] touch_v;
    logic [ADDR_W-1:0]    addr_v [N_REGIONS];

    for (genvar i = 0; i < N_REGIONS; i++) begin : g_region
        terrain_region #(
            .SHEET_W (SHEET_W)
        ) u_region (
            .clk   (clk),
            .rst_n (rst_n),
            .ph    (PH[map_sel][i]),
            .pv    (PV[map_sel][i]),
            .w     (W[map_sel][i]),
            .h     (H[i]),
            .mh    (MH[i]),
            .mv    (MV[i]),
            .px    (player.px),
            .py    (player.py),
            .vga_h (vga_h),
            .vga_v (vga_v),
            .hit   (hit_v[i]),
            .addr  (addr_v[i]),
            .touch (touch_v[i])
        );
    end

    // first hit wins, so walk from the lowest priority up.
    always_comb begin
        terrain_hit  = 1'b0;
        terrain_addr = '0;
        for (int i = N_REGIONS - 1; i >= 0; i--) begin
            if (hit_v[i]) begin
                terrain_hit  = 1'b1;
                terrain_addr = addr_v[i];
            end
        end
    end

    always_comb begin
        touch_solid = 1'b0;
        touch_red   = 1'b0;
        touch_blue  = 1'b0;
        for (int i = 0; i < N_REGIONS; i++) begin
            if (touch_v[i]) begin
                case (KIND[i])
                    KIND_SOLID: touch_solid = 1'b1;
                    KIND_RED:   touch_red   = 1'b1;
                    KIND_BLUE:  touch_blue  = 1'b1;
                    default:    ;
                endcase
            end
        end
    end

    a_map_sel_known : assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(map_sel));

endmodule

/* src/terrain_region.sv */
`timescale 1ns/1ps

module terrain_region import scene_pkg::*; #(
    parameter int SHEET_W = 320
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [COORD_W-1:0] ph,
    input  logic [COORD_W-1:0] pv,
    input  logic [COORD_W-1:0] w,
    input  logic [COORD_W-1:0] h,
    input  logic [COORD_W-1:0] mh,
    input  logic [COORD_W-1:0] mv,
    input  logic [COORD_W-1:0] px,
    input  logic [COORD_W-1:0] py,
    input  logic [COORD_W-1:0] vga_h,
    input  logic [COORD_W-1:0] vga_v,
    output logic               hit,
    output logic [ADDR_W-1:0]  addr,
    output logic               touch
);

    localparam int EXT_W = COORD_W + 1;

    logic [EXT_W-1:0]  h_end, v_end;   // one past the far edges.
    logic [EXT_W-1:0]  box_r, box_b;
    logic              pix_in, over;
    logic [ADDR_W-1:0] row, col;

    assign h_end = EXT_W'(ph) + EXT_W'(w);
    assign v_end = EXT_W'(pv) + EXT_W'(h);
    assign box_r = EXT_W'(px) + EXT_W'(PLAYER_W);
    assign box_b = EXT_W'(py) + EXT_W'(PLAYER_H);

    assign pix_in = (vga_h >= ph) && (EXT_W'(vga_h) < h_end) &&
                    (vga_v >= pv) && (EXT_W'(vga_v) < v_end);

    // player box against the region rectangle.
    assign over = (EXT_W'(px) < h_end) && (box_r > EXT_W'(ph)) &&
                  (EXT_W'(py) < v_end) && (box_b > EXT_W'(pv));

    assign row = ADDR_W'(mv) + ADDR_W'(vga_v) - ADDR_W'(pv);
    assign col = ADDR_W'(mh) + ADDR_W'(vga_h) - ADDR_W'(ph);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit   <= 1'b0;
            touch <= 1'b0;
        end else begin
            hit   <= pix_in;
            touch <= over;
        end
    end

    always_ff @(posedge clk) begin
        addr <= ADDR_W'(row * SHEET_W) + col;  // only meaningful with hit.
    end

    // the map tables must keep every region inside the sheet.
    a_addr_in_sheet : assert property (@(posedge clk) disable iff (!rst_n)
        hit |-> (int'(addr) < SHEET_W * SCREEN_H));

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge away from the sampling edge.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* tb/tb_scene.sv */
`timescale 1ns/1ps

module tb_scene import scene_pkg::*; ();

    localparam int                 SHEET_W   = 320;
    localparam logic [ADDR_W-1:0]  BG_ADDR   = 17'd12900;
    localparam logic [31:0]        LFSR_SEED = 32'hb53e_2ed1;
    localparam logic [31:0]        LFSR_TAPS = 32'h8020_0003;
    localparam logic [COORD_W-1:0] OFF       = 10'd1000;  // parks the player off-screen.

    // ----------------------------------------
    // layouts as ph, pv, w, h, mh, mv, kind
    // ----------------------------------------
    localparam int MAP0 [N_REGIONS][7] = '{
        '{0, 0, 320, 10, 0, 220, 0},
        '{150, 230, 40, 6, 0, 65, 1},
        '{210, 230, 40, 6, 55, 70, 2},
        '{0, 230, 320, 10, 0, 220, 0},
        '{0, 10, 10, 220, 305, 10, 0},
        '{310, 10, 10, 220, 305, 10, 0},
        '{10, 190, 105, 8, 50, 215, 0}
    };
    localparam int MAP1 [N_REGIONS][7] = '{
        '{0, 0, 320, 10, 0, 220, 0},
        '{60, 230, 40, 6, 0, 65, 1},
        '{240, 230, 40, 6, 55, 70, 2},
        '{0, 230, 320, 10, 0, 220, 0},
        '{0, 10, 10, 220, 305, 10, 0},
        '{310, 10, 10, 220, 305, 10, 0},
        '{200, 150, 110, 8, 50, 215, 0}
    };

    localparam logic [3:0] STATES [6] = '{ST_STATIC, ST_RIGHT, ST_LEFT, ST_UP, 4'd0, 4'd15};
    localparam int SPOT_X [2] = '{100, 40};  // on the floor, over the wall.
    localparam int SPOT_Y [2] = '{212, 185};
    // map, x, y of each collision placement.
    localparam int TOUCH_SPOTS [8][3] = '{
        '{0, 160, 215}, '{0, 220, 215}, '{0, 50, 180}, '{0, 150, 100},
        '{1, 70, 215}, '{1, 250, 215}, '{1, 220, 140}, '{1, 100, 100}
    };

    localparam int SCAN_W      = SCREEN_W + 4;  // a few pixels past the edges.
    localparam int SCAN_H      = SCREEN_H + 2;
    localparam int N_SPRITE    = 2 * 6 * 4 * (PLAYER_W + 4) * (PLAYER_H + 4);
    localparam int N_TOUCH     = 16;
    localparam int N_RANDOM    = 3000;
    localparam int N_STIM      = 2 * SCAN_W * SCAN_H + N_SPRITE + N_TOUCH + N_RANDOM + 2;
    localparam int CYCLE_LIMIT = 2 * N_STIM + 100;

    logic               clk, rst_n, map_sel;
    logic [COORD_W-1:0] vga_h, vga_v, player_x, player_y;
    logic [3:0]         player_state;
    logic [1:0]         player_jump;
    logic [ADDR_W-1:0]  addr;
    logic               sprite_on, touch_solid, touch_red, touch_blue;

    logic [ADDR_W-1:0]    exp_addr_q [$];
    logic                 exp_on_q [$];
    logic [2:0]           exp_touch_q [$];
    logic [2*COORD_W-1:0] pix_q [$];
    logic [31:0]          lfsr = LFSR_SEED;
    int                   addr_errors = 0;
    int                   touch_errors = 0;
    int                   cycles = 0;

    tb_clock #(.PERIOD (8), .RESET_CYCLES (8)) u_clock (.clk (clk), .rst_n (rst_n));

    scene_top #(
        .SHEET_W (SHEET_W),
        .BG_ADDR (BG_ADDR)
    ) i_scene_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .map_sel      (map_sel),
        .vga_h        (vga_h),
        .vga_v        (vga_v),
        .player_x     (player_x),
        .player_y     (player_y),
        .player_state (player_state),
        .player_jump  (player_jump),
        .addr         (addr),
        .sprite_on    (sprite_on),
        .touch_solid  (touch_solid),
        .touch_red    (touch_red),
        .touch_blue   (touch_blue)
    );

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic int layout_field(input int mi, input int r, input int f);
        if (mi == 1) begin
            return MAP1[r][f];
        end
        return MAP0[r][f];
    endfunction

    function automatic logic [ADDR_W-1:0] ref_addr(input logic m,
            input logic [COORD_W-1:0] x, y, pxv, pyv,
            input logic [3:0] st, input logic [1:0] jp, output logic on);
        int xi, yi, pxi, pyi, mi, frame, ph, pv;
        xi = int'(x);
        yi = int'(y);
        pxi = int'(pxv);
        pyi = int'(pyv);
        mi = m ? 1 : 0;
        on = 1'b0;
        if (xi >= pxi && xi < pxi + PLAYER_W && yi >= pyi && yi < pyi + PLAYER_H &&
                xi < SCREEN_W && yi < SCREEN_H) begin
            on = 1'b1;
            case (st)
                ST_RIGHT: frame = 1;
                ST_LEFT:  frame = 2;
                ST_UP:    frame = 3;
                default:  frame = 0;
            endcase
            if (jp != 2'd0) begin
                frame = 3;  // jumping always shows the up frame.
            end
            return ADDR_W'((PLAYER_MEM_V + yi - pyi) * SHEET_W + PLAYER_MEM_H +
                           frame * PLAYER_W + xi - pxi);
        end
        for (int r = 0; r < N_REGIONS; r++) begin
            ph = layout_field(mi, r, 0);
            pv = layout_field(mi, r, 1);
            if (xi >= ph && xi < ph + layout_field(mi, r, 2) &&
                    yi >= pv && yi < pv + layout_field(mi, r, 3)) begin
                return ADDR_W'((layout_field(mi, r, 5) + yi - pv) * SHEET_W +
                               layout_field(mi, r, 4) + xi - ph);
            end
        end
        return BG_ADDR;
    endfunction

    // solid, red, blue.
    function automatic logic [2:0] ref_touch(input logic m, input logic [COORD_W-1:0] pxv, pyv);
        logic [2:0] t;
        int         mi, ph, pv, k;
        t = 3'b000;
        mi = m ? 1 : 0;
        for (int r = 0; r < N_REGIONS; r++) begin
            ph = layout_field(mi, r, 0);
            pv = layout_field(mi, r, 1);
            k = layout_field(mi, r, 6);
            if (int'(pxv) < ph + layout_field(mi, r, 2) && int'(pxv) + PLAYER_W > ph &&
                    int'(pyv) < pv + layout_field(mi, r, 3) && int'(pyv) + PLAYER_H > pv) begin
                if (k == int'(KIND_SOLID)) t[2] = 1'b1;
                if (k == int'(KIND_RED)) t[1] = 1'b1;
                if (k == int'(KIND_BLUE)) t[0] = 1'b1;
            end
        end
        return t;
    endfunction

    // galois lfsr stepped once per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
        end
        return v;
    endfunction

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
            input logic got_on, input logic exp_on, input logic [2*COORD_W-1:0] pix);
        if (got !== exp || got_on !== exp_on) begin
            addr_errors++;
            $display("FAILED %0t: pixel (%0d,%0d) addr %0d sprite_on %b, expected %0d %b",
                     $time, pix[2*COORD_W-1:COORD_W], pix[COORD_W-1:0], got, got_on,
                     exp, exp_on);
        end
    endtask

    task automatic check_touch(input logic got_solid, input logic got_red,
            input logic got_blue, input logic [2:0] exp);
        if ({got_solid, got_red, got_blue} !== exp) begin
            touch_errors++;
            $display("FAILED %0t: touch solid/red/blue %b%b%b, expected %b", $time,
                     got_solid, got_red, got_blue, exp);
        end
    endtask

    // outputs are read before the edge updates them.
    always @(posedge clk) begin
        if (exp_addr_q.size() >= 3) begin
            check_addr(addr, exp_addr_q.pop_front(), sprite_on, exp_on_q.pop_front(),
                       pix_q.pop_front());
        end
        if (exp_touch_q.size() >= 2) begin
            check_touch(touch_solid, touch_red, touch_blue, exp_touch_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic drive_pixel(input logic m, input logic [COORD_W-1:0] x, y, pxv, pyv,
            input logic [3:0] st, input logic [1:0] jp);
        logic on;
        @(negedge clk);
        map_sel = m;
        vga_h = x;
        vga_v = y;
        player_x = pxv;
        player_y = pyv;
        player_state = st;
        player_jump = jp;
        exp_addr_q.push_back(ref_addr(m, x, y, pxv, pyv, st, jp, on));
        exp_on_q.push_back(on);
        exp_touch_q.push_back(ref_touch(m, pxv, pyv));
        pix_q.push_back({x, y});
    endtask

    task automatic scan_map(input logic m);
        for (int y = 0; y < SCAN_H; y++) begin
            for (int x = 0; x < SCAN_W; x++) begin
                drive_pixel(m, COORD_W'(x), COORD_W'(y), OFF, OFF, ST_STATIC, 2'd0);
            end
        end
    endtask

    task automatic sprite_frames();
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < 6; s++) begin
                for (int j = 0; j < 4; j++) begin
                    for (int y = SPOT_Y[p] - 2; y < SPOT_Y[p] + PLAYER_H + 2; y++) begin
                        for (int x = SPOT_X[p] - 2; x < SPOT_X[p] + PLAYER_W + 2; x++) begin
                            drive_pixel(1'b0, COORD_W'(x), COORD_W'(y), COORD_W'(SPOT_X[p]),
                                        COORD_W'(SPOT_Y[p]), STATES[s], 2'(j));
                        end
                    end
                end
            end
        end
    endtask

    task automatic touch_moves();
        for (int i = 0; i < 8; i++) begin
            repeat (2) drive_pixel(1'(TOUCH_SPOTS[i][0]), COORD_W'(TOUCH_SPOTS[i][1]),
                                   COORD_W'(TOUCH_SPOTS[i][2]), COORD_W'(TOUCH_SPOTS[i][1]),
                                   COORD_W'(TOUCH_SPOTS[i][2]), ST_RIGHT, 2'd0);
        end
    endtask

    task automatic random_pixels();
        logic [COORD_W-1:0] x, y, pxv, pyv;
        logic               m;
        logic [3:0]         st;
        logic [1:0]         jp;
        repeat (N_RANDOM) begin
            m = 1'(take_bits(1));
            pxv = COORD_W'(take_bits(9));
            pyv = COORD_W'(take_bits(8));
            st = 4'(take_bits(4));
            jp = 2'(take_bits(2));
            if (take_bits(1) != 32'd0) begin
                x = pxv + COORD_W'(take_bits(5)) - COORD_W'(4);  // near the player box.
                y = pyv + COORD_W'(take_bits(5)) - COORD_W'(4);
            end else begin
                x = COORD_W'(take_bits(9));
                y = COORD_W'(take_bits(8));
            end
            drive_pixel(m, x, y, pxv, pyv, st, jp);
        end
    endtask

    initial begin
        map_sel = 1'b0;
        vga_h = OFF;
        vga_v = OFF;
        player_x = OFF;
        player_y = OFF;
        player_state = ST_STATIC;
        player_jump = 2'd0;

        @(posedge rst_n);
        check_addr(addr, BG_ADDR, sprite_on, 1'b0, '0);
        check_touch(touch_solid, touch_red, touch_blue, 3'b000);

        scan_map(1'b0);
        scan_map(1'b1);
        sprite_frames();
        touch_moves();
        random_pixels();
        repeat (2) drive_pixel(1'b0, OFF, OFF, OFF, OFF, ST_STATIC, 2'd0);
        @(posedge clk);
        @(negedge clk);

        $display("errors: addr %0d, touch %0d", addr_errors, touch_errors);
        if (addr_errors + touch_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
